//--- common/sifh_defs.svh
`ifndef SIFH_DEFS_SVH
`define SIFH_DEFS_SVH

// Histogram geometry.
`define BIN_NUM 16
`define BIN_W 4

// Sensor geometry.
`define PIXEL_NUM 4
`define PIXEL_W 2

// Strobes per pixel in one frame.
`define DATA_NUM 2

// Frames per acquisition.
`define ACQ_NUM 8

// Counts saturate here.
`define PEAK_MAX 7
`define CNT_W 3

// Address is {pixel, bin}.
`define ADDR_W 6

`endif

//--- common/hist_pkg.sv
`include "sifh_defs.svh"

package hist_pkg;

    // One histogram count.
    typedef logic [`CNT_W-1:0] count_t;

    // Read request to the histogram memory.
    typedef struct packed {
        logic              en;
        logic [`ADDR_W-1:0] addr;
    } mem_rd_req_t;

    // Write request to the histogram memory.
    typedef struct packed {
        logic              en;
        logic [`ADDR_W-1:0] addr;
        count_t            data;
    } mem_wr_req_t;

endpackage

//--- common/peak_pkg.sv
`include "sifh_defs.svh"

package peak_pkg;

    // Acquisition phases, in the order the controller steps through them.
    typedef enum logic [1:0] {
        phase_idle  = 2'b00,
        phase_build = 2'b01,
        phase_find  = 2'b10,
        phase_wait  = 2'b11
    } acq_phase_t;

    // Peak bin of every pixel, pixel 0 in the low bits.
    typedef logic [`PIXEL_NUM-1:0][`BIN_W-1:0] peak_result_t;

endpackage

//--- hdl/acq_controller.sv
`timescale 1ns/1ps
`include "sifh_defs.svh"

module acq_controller (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   wr_en,
    input  logic                   find_done,
    output logic                   hist_strobe,
    output logic [`PIXEL_W-1:0]    pixel,
    output logic                   find_start,
    output peak_pkg::acq_phase_t   phase
);

    localparam int data_w  = $clog2(`DATA_NUM);
    localparam int frame_w = $clog2(`ACQ_NUM);

    logic [data_w-1:0]   data_cnt;
    logic [`PIXEL_W-1:0] pixel_cnt;
    logic [frame_w-1:0]  frame_cnt;
    logic                last_data;
    logic                last_pixel;
    logic                last_frame;
    logic                last_strobe;
    peak_pkg::acq_phase_t phase_next;

    // Strobes only count while idle or building.
    assign hist_strobe = wr_en &&
        (phase == peak_pkg::phase_idle || phase == peak_pkg::phase_build);

    assign last_data   = data_cnt == data_w'(`DATA_NUM - 1);
    assign last_pixel  = pixel_cnt == `PIXEL_W'(`PIXEL_NUM - 1);
    assign last_frame  = frame_cnt == frame_w'(`ACQ_NUM - 1);
    assign last_strobe = hist_strobe && last_data && last_pixel && last_frame;

    assign pixel = pixel_cnt;

    // Nested counters wrap back to zero after the last strobe.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            data_cnt  <= '0;
            pixel_cnt <= '0;
            frame_cnt <= '0;
        end else if (hist_strobe) begin
            if (last_data) begin
                data_cnt <= '0;
                if (last_pixel) begin
                    pixel_cnt <= '0;
                    if (last_frame)
                        frame_cnt <= '0;
                    else
                        frame_cnt <= frame_cnt + 1'b1;
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end else begin
                data_cnt <= data_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        phase_next = phase;
        case (phase)
            peak_pkg::phase_idle,
            peak_pkg::phase_build: begin
                if (last_strobe)
                    phase_next = peak_pkg::phase_find;
                else if (hist_strobe)
                    phase_next = peak_pkg::phase_build;
            end
            peak_pkg::phase_find: begin
                if (find_done)
                    phase_next = peak_pkg::phase_wait;
            end
            default: begin
                phase_next = peak_pkg::phase_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase      <= peak_pkg::phase_idle;
            find_start <= 1'b0;
        end else begin
            phase      <= phase_next;
            find_start <= last_strobe;
        end
    end

endmodule

//--- histogram/hist_builder.sv
`timescale 1ns/1ps
`include "sifh_defs.svh"

module hist_builder (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  strobe,
    input  logic [`PIXEL_W-1:0]   pixel,
    input  logic [`BIN_W-1:0]     bin,
    input  hist_pkg::count_t      rd_data,
    output hist_pkg::mem_rd_req_t rd_req,
    output hist_pkg::mem_wr_req_t wr_req
);

    localparam hist_pkg::count_t peak_max = `CNT_W'(`PEAK_MAX);

    logic                 s1_valid;
    logic [`ADDR_W-1:0]   s1_addr;
    logic                 prev_wr;
    logic [`ADDR_W-1:0]   prev_addr;
    hist_pkg::count_t     prev_cnt;
    logic                 fwd;
    hist_pkg::count_t     base_cnt;
    hist_pkg::count_t     next_cnt;

    // Stage 1 reads the bin of the incoming strobe.
    assign rd_req.en   = strobe;
    assign rd_req.addr = {pixel, bin};

    // The write from the previous cycle is not yet in the read data.
    assign fwd      = prev_wr && (prev_addr == s1_addr);
    assign base_cnt = fwd ? prev_cnt : rd_data;
    assign next_cnt = (base_cnt == peak_max) ? base_cnt : base_cnt + 1'b1;

    // Stage 2 writes the incremented count back.
    assign wr_req.en   = s1_valid;
    assign wr_req.addr = s1_addr;
    assign wr_req.data = next_cnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            prev_wr  <= 1'b0;
        end else begin
            s1_valid <= strobe;
            prev_wr  <= s1_valid;
        end
    end

    // Address and count payload.
    always_ff @(posedge clk) begin
        if (strobe)
            s1_addr <= {pixel, bin};
        if (s1_valid) begin
            prev_addr <= s1_addr;
            prev_cnt  <= next_cnt;
        end
    end

endmodule

//--- peak/peak_finder.sv
`timescale 1ns/1ps
`include "sifh_defs.svh"

module peak_finder (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   find_start,
    input  peak_pkg::acq_phase_t   phase,
    input  logic                   rd_grant,
    input  logic                   wr_grant,
    input  hist_pkg::count_t       rd_data,
    output hist_pkg::mem_rd_req_t  rd_req,
    output hist_pkg::mem_wr_req_t  wr_req,
    output logic                   find_done,
    output peak_pkg::peak_result_t result,
    output logic                   result_valid,
    output logic                   busy
);

    localparam logic [`ADDR_W-1:0] last_addr = '1;
    localparam logic [`BIN_W-1:0]  last_bin  = `BIN_W'(`BIN_NUM - 1);

    logic                   running;
    logic [`ADDR_W-1:0]     rd_addr;
    logic                   stall;
    logic                   issue;
    logic                   s1_valid;
    logic [`ADDR_W-1:0]     s1_addr;
    logic                   s2_valid;
    logic [`ADDR_W-1:0]     s2_addr;
    logic                   last_wr;
    logic                   done_q;
    logic [`BIN_W-1:0]      s1_bin;
    logic [`PIXEL_W-1:0]    s1_pixel;
    logic                   take;
    hist_pkg::count_t       max_cnt;
    logic [`BIN_W-1:0]      max_bin;
    peak_pkg::peak_result_t peaks;

    assign busy = phase != peak_pkg::phase_idle;

    // A refused zero write freezes the whole scan.
    assign stall = s2_valid && !wr_grant;
    assign issue = rd_req.en && rd_grant;

    assign rd_req.en   = running && !stall;
    assign rd_req.addr = rd_addr;

    assign wr_req.en   = s2_valid;
    assign wr_req.addr = s2_addr;
    assign wr_req.data = '0;

    assign s1_bin   = s1_addr[`BIN_W-1:0];
    assign s1_pixel = s1_addr[`ADDR_W-1:`BIN_W];
    // Strictly greater, so the lowest bin keeps a tie.
    assign take     = (s1_bin == '0) || (rd_data > max_cnt);

    // The last zero write ends the scan, all peaks are known by then.
    assign last_wr = s2_valid && wr_grant && (s2_addr == last_addr);

    assign find_done    = done_q;
    assign result_valid = done_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            running  <= 1'b0;
            rd_addr  <= '0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            done_q   <= 1'b0;
            result   <= '0;
        end else begin
            if (find_start) begin
                running <= 1'b1;
                rd_addr <= '0;
            end else if (issue) begin
                rd_addr <= rd_addr + 1'b1;
                if (rd_addr == last_addr)
                    running <= 1'b0;
            end
            if (!stall) begin
                s1_valid <= issue;
                s2_valid <= s1_valid;
            end
            done_q <= last_wr;
            if (last_wr)
                result <= peaks;
        end
    end

    // Scan payload.
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_addr <= rd_addr;
            s2_addr <= s1_addr;
            if (s1_valid) begin
                if (take) begin
                    max_cnt <= rd_data;
                    max_bin <= s1_bin;
                end
                if (s1_bin == last_bin)
                    peaks[s1_pixel] <= take ? s1_bin : max_bin;
            end
        end
    end

endmodule

//--- hdl/hist_mem_arbiter.sv
`timescale 1ns/1ps
`include "sifh_defs.svh"

module hist_mem_arbiter (
    input  logic                  clk,
    input  logic                  res,
    input  hist_pkg::mem_rd_req_t rd_req0,
    input  hist_pkg::mem_wr_req_t wr_req0,
    input  hist_pkg::mem_rd_req_t rd_req1,
    input  hist_pkg::mem_wr_req_t wr_req1,
    output logic                  rd_grant1,
    output logic                  wr_grant1,
    output hist_pkg::count_t      rd_data
);

    localparam int depth = `BIN_NUM * `PIXEL_NUM;

    hist_pkg::count_t      mem [depth];
    hist_pkg::mem_rd_req_t rd_sel;
    hist_pkg::mem_wr_req_t wr_sel;

    // Requester 0 always wins its port.
    assign rd_grant1 = rd_req1.en && !rd_req0.en;
    assign wr_grant1 = wr_req1.en && !wr_req0.en;

    assign rd_sel = rd_req0.en ? rd_req0 : rd_req1;
    assign wr_sel = wr_req0.en ? wr_req0 : wr_req1;

    // Read data is held while nobody reads.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_data <= '0;
        end else if (rd_sel.en) begin
            rd_data <= mem[rd_sel.addr];
        end
    end

    // Reads see the value from before a write in the same cycle.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_sel.en) begin
            mem[wr_sel.addr] <= wr_sel.data;
        end
    end

endmodule

//--- hdl/sifh_top.sv
`timescale 1ns/1ps
`include "sifh_defs.svh"

module sifh_top (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   wr_en,
    input  logic [`BIN_W-1:0]      data,
    output peak_pkg::peak_result_t result,
    output logic                   result_valid,
    output logic                   busy
);

    logic                  hist_strobe;
    logic [`PIXEL_W-1:0]   pixel;
    logic                  find_start;
    logic                  find_done;
    peak_pkg::acq_phase_t  phase;
    hist_pkg::mem_rd_req_t bld_rd_req;
    hist_pkg::mem_wr_req_t bld_wr_req;
    hist_pkg::mem_rd_req_t fnd_rd_req;
    hist_pkg::mem_wr_req_t fnd_wr_req;
    logic                  fnd_rd_grant;
    logic                  fnd_wr_grant;
    hist_pkg::count_t      rd_data;

    acq_controller u_ctrl (
        .clk(clk), .res(res), .wr_en(wr_en), .find_done(find_done),
        .hist_strobe(hist_strobe), .pixel(pixel), .find_start(find_start), .phase(phase)
    );

    hist_builder u_builder (
        .clk(clk), .res(res), .strobe(hist_strobe), .pixel(pixel), .bin(data),
        .rd_data(rd_data), .rd_req(bld_rd_req), .wr_req(bld_wr_req)
    );

    peak_finder u_finder (
        .clk(clk), .res(res), .find_start(find_start), .phase(phase),
        .rd_grant(fnd_rd_grant), .wr_grant(fnd_wr_grant), .rd_data(rd_data),
        .rd_req(fnd_rd_req), .wr_req(fnd_wr_req), .find_done(find_done),
        .result(result), .result_valid(result_valid), .busy(busy)
    );

    hist_mem_arbiter u_arb (
        .clk(clk), .res(res), .rd_req0(bld_rd_req), .wr_req0(bld_wr_req),
        .rd_req1(fnd_rd_req), .wr_req1(fnd_wr_req), .rd_grant1(fnd_rd_grant),
        .wr_grant1(fnd_wr_grant), .rd_data(rd_data)
    );

endmodule

//--- tb/sifh_tb.sv
`timescale 1ns/1ps
`include "sifh_defs.svh"

module sifh_tb;

    localparam int reset_cycles    = 10;
    localparam int acq_total       = 3;
    localparam int strobes_per_acq = `DATA_NUM * `PIXEL_NUM * `ACQ_NUM;
    localparam int pat_words       = acq_total * strobes_per_acq + acq_total;
    localparam int result_wait     = 200;
    localparam int cycle_limit     = reset_cycles + acq_total * (strobes_per_acq * 4 + 200);

    logic                   clk = 1'b0;
    logic                   res;
    logic                   wr_en;
    logic [`BIN_W-1:0]      data;
    peak_pkg::peak_result_t result;
    logic                   result_valid;
    logic                   busy;

    logic [`PIXEL_NUM*`BIN_W-1:0] pat_mem [0:pat_words-1];

    int                     value_errors = 0;
    int                     event_errors = 0;
    int                     pulse_cnt = 0;
    int                     cycle_cnt = 0;
    int                     rand_seed;
    peak_pkg::peak_result_t result_q = '0;
    logic                   valid_q = 1'b0;

    sifh_top dut (
        .clk(clk),
        .res(res),
        .wr_en(wr_en),
        .data(data),
        .result(result),
        .result_valid(result_valid),
        .busy(busy)
    );

    always #10 clk = ~clk;

    task automatic check_result(input string name, input peak_pkg::peak_result_t got,
                                input peak_pkg::peak_result_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d wrong values, %0d protocol errors", value_errors, event_errors);
    endtask

    // Saturating histogram of one acquisition, lowest bin keeps a tie.
    function automatic peak_pkg::peak_result_t model_peaks(input int acq);
        int                     counts [`PIXEL_NUM][`BIN_NUM];
        int                     pix;
        int                     bin;
        int                     best;
        peak_pkg::peak_result_t peaks_v;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            for (int b = 0; b < `BIN_NUM; b++) begin
                counts[p][b] = 0;
            end
        end
        for (int i = 0; i < strobes_per_acq; i++) begin
            pix = (i / `DATA_NUM) % `PIXEL_NUM;
            bin = int'(pat_mem[acq * strobes_per_acq + i][`BIN_W-1:0]);
            if (counts[pix][bin] < `PEAK_MAX)
                counts[pix][bin]++;
        end
        peaks_v = '0;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            best = 0;
            for (int b = 1; b < `BIN_NUM; b++) begin
                if (counts[p][b] > counts[p][best])
                    best = b;
            end
            peaks_v[p] = `BIN_W'(best);
        end
        return peaks_v;
    endfunction

    task automatic send_strobe(input logic [`BIN_W-1:0] bin);
        @(posedge clk);
        wr_en <= 1'b1;
        data  <= bin;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic run_acquisition(input int acq);
        int                     gap;
        int                     waited;
        int                     pulses_before;
        logic                   found;
        peak_pkg::peak_result_t expected;
        pulses_before = pulse_cnt;
        expected = pat_mem[acq_total * strobes_per_acq + acq];
        check_result("model peaks", model_peaks(acq), expected);

        // Busy follows the phase, so it rises one edge after the first strobe.
        send_strobe(pat_mem[acq * strobes_per_acq][`BIN_W-1:0]);
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        idle_cycle();
        @(negedge clk);
        check_flag("busy", busy, 1'b1);

        for (int i = 1; i < strobes_per_acq; i++) begin
            // Acquisition 2 keeps each pixel's pair back to back for forwarding.
            if (acq == 1 && (i % `DATA_NUM) != 0)
                gap = 0;
            else
                gap = int'($urandom % 4);
            repeat (gap) idle_cycle();
            send_strobe(pat_mem[acq * strobes_per_acq + i][`BIN_W-1:0]);
        end
        idle_cycle();

        found  = 1'b0;
        waited = 0;
        while (!found && waited < result_wait) begin
            @(negedge clk);
            if (result_valid)
                found = 1'b1;
            waited++;
        end
        if (!found) begin
            $display("Acquisition %0d: no result_valid within %0d cycles", acq + 1,
                     result_wait);
            event_errors++;
        end else begin
            check_flag("busy", busy, 1'b1);
            check_result("result", result, expected);
        end

        waited = 0;
        while (busy && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        check_flag("busy", busy, 1'b0);
        repeat (4) @(negedge clk);
        if (pulse_cnt - pulses_before != 1) begin
            $display("Acquisition %0d: saw %0d result_valid pulses instead of one", acq + 1,
                     pulse_cnt - pulses_before);
            event_errors++;
        end
    endtask

    // Pulse width, pulse count and result stability between pulses.
    always @(negedge clk) begin
        if (res) begin
            if (result_valid) begin
                pulse_cnt++;
                if (valid_q) begin
                    $display("result_valid stayed high for more than one cycle");
                    event_errors++;
                end
            end
            // Result may only change together with result_valid.
            if (!result_valid)
                check_result("result between pulses", result, result_q);
            result_q = result;
            valid_q  = result_valid;
        end
    end

    initial begin
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not end within %0d cycles", cycle_limit);
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rand_seed = 67906;
        void'($urandom(rand_seed));
        res   = 1'b0;
        wr_en = 1'b0;
        data  = '0;
        $readmemh("tb/sifh_patterns.txt", pat_mem);
        repeat (reset_cycles) @(posedge clk);
        res <= 1'b1;

        @(negedge clk);
        check_flag("result_valid", result_valid, 1'b0);
        check_flag("busy", busy, 1'b0);

        // No reset between acquisitions, so each one relies on the cleared bins.
        for (int acq = 0; acq < acq_total; acq++) begin
            run_acquisition(acq);
        end

        print_counts();
        if (value_errors + event_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb/sifh_patterns.txt
// Columns: one bin index per strobe, 16 strobes (two frames) per line.
// Frame order: pixel 0 twice, pixel 1 twice, pixel 2 twice, pixel 3 twice.
// Acquisition 1, distinct peaks.
3 1 9 8 c c 5 6 3 2 9 a c d 5 6
3 1 9 8 b c 6 5 3 4 9 b c a 5 4
3 0 8 9 5 c 5 3 3 7 9 0 d d 2 5
2 1 a e e c 6 6 4 f 9 6 f 0 1 0
// Acquisition 2, repeated bins and saturated ties.
6 6 a a f f 9 9 6 6 a a f f 9 9
6 6 a a f f 9 9 6 6 a a f f 9 9
2 2 4 4 f f 7 7 2 2 4 4 f f 7 7
2 2 4 4 f f 7 7 2 2 4 4 f f 7 7
// Acquisition 3, low counts on bins that were full before.
8 b b 1 3 0 e e 8 c b 1 3 1 e e
8 d b 1 3 2 0 1 8 e 2 3 3 4 2 3
b c 5 6 3 5 4 5 d e 7 8 6 7 6 8
b 1 9 c 8 9 a b c 3 d e a b c d
// Expected result per acquisition, pixel 3 in the high digit.
5c93
7f42
e318

//--- flist.f
+incdir+common
common/hist_pkg.sv
common/peak_pkg.sv
hdl/acq_controller.sv
histogram/hist_builder.sv
peak/peak_finder.sv
hdl/hist_mem_arbiter.sv
hdl/sifh_top.sv
tb/sifh_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the histogram testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module sifh_tb \
    -Mdir obj_dir -o sifh_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sifh_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TEST PASSED" "$LOG"; then
    echo "Simulation ended without a verdict"
    exit 1
fi

exit 0
